/* hdl/rot_entropy_pkg.sv */
`default_nettype none

package rot_entropy_pkg;

  // fixed configuration of the entropy chain
  localparam int NumEndPoints = 4;

  // raw samples packed into one seed word
  localparam int SamplesPerWord = 8;

  // identical samples in a row that fail the repetition test
  localparam int RepCntThresh = 8;

  // generate steps allowed between two reseeds
  localparam int GenPerReseed = 4;

  // one raw noise sample
  typedef logic [3:0] rng_sample_t;

  // seed, generator state and output word
  typedef logic [31:0] seed_word_t;

  // one bit per endpoint
  typedef logic [NumEndPoints-1:0] ep_mask_t;
  typedef logic [$clog2(NumEndPoints)-1:0] ep_idx_t;

  // generate steps since the last reseed
  typedef logic [2:0] reseed_cnt_t;

  // samples held in the packing register
  typedef logic [$clog2(SamplesPerWord)-1:0] pack_cnt_t;

  // length of the current run of identical samples
  typedef logic [$clog2(RepCntThresh + 1)-1:0] rep_cnt_t;

  // generator state after reset
  localparam seed_word_t CsrngInitState = 32'h1f2e_3d4c;

  // galois feedback mask, applied when a 1 is shifted out
  localparam seed_word_t CsrngLfsrTaps = 32'h8020_0003;

  // generator FSM
  typedef enum logic [1:0] {
    CsIdle,
    CsReseed,
    CsGen,
    CsAck
  } cs_state_e;

  // distribution FSM
  typedef enum logic [1:0] {
    EdnIdle,
    EdnFetch,
    EdnAck,
    EdnRelease
  } edn_state_e;

endpackage

`default_nettype wire

/* hdl/entropy_src.sv */
`timescale 1ns/1ps
`default_nettype none

module entropy_src (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  rot_entropy_pkg::rng_sample_t es_rng_sample_i,
  input  logic                        es_rng_valid_i,
  output logic                        es_rng_enable_o,
  input  logic                        seed_req_i,
  output logic                        seed_ack_o,
  output rot_entropy_pkg::seed_word_t  seed_data_o,
  output logic                        intr_es_health_test_failed_o
);

  import rot_entropy_pkg::*;

  // packing state
  seed_word_t  pack_q;
  pack_cnt_t   pack_cnt_q;
  seed_word_t  packed_word;

  // seed buffer and handshake
  seed_word_t  seed_buf_q;
  logic        buf_full_q;
  logic        seed_ack_q;

  // repetition count test
  rng_sample_t last_sample_q;
  rep_cnt_t    rep_cnt_q;
  rep_cnt_t    rep_cnt_d;
  logic        same_sample;
  logic        health_fail;
  logic        intr_q;

  logic        rng_accept;
  logic        word_done;

  // noise source stalls while the buffer holds a word
  assign es_rng_enable_o = ~buf_full_q;
  assign rng_accept      = es_rng_valid_i & es_rng_enable_o;

  // first sample ends up in bits 3:0
  assign packed_word = {es_rng_sample_i, pack_q[$bits(seed_word_t)-1:$bits(rng_sample_t)]};

  // rep_cnt_q of zero means no run in progress
  assign same_sample = (rep_cnt_q != '0) && (es_rng_sample_i == last_sample_q);
  assign rep_cnt_d   = same_sample ? rep_cnt_q + 1'b1 : rep_cnt_t'(1);
  assign health_fail = rng_accept && (rep_cnt_d == rep_cnt_t'(RepCntThresh));

  // a failing sample never completes a word
  assign word_done = rng_accept && !health_fail &&
                     (pack_cnt_q == pack_cnt_t'(SamplesPerWord - 1));

  // sample datapath
  always_ff @(posedge clk_i) begin
    if (rng_accept) begin
      pack_q        <= packed_word;
      last_sample_q <= es_rng_sample_i;
    end
    if (word_done) begin
      seed_buf_q <= packed_word;
    end
  end

  // packing count and health test
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pack_cnt_q <= '0;
      rep_cnt_q  <= '0;
      intr_q     <= 1'b0;
    end else if (rng_accept) begin
      if (health_fail) begin
        // drop the partial word, restart packing and the run
        pack_cnt_q <= '0;
        rep_cnt_q  <= '0;
        intr_q     <= 1'b1;
      end else begin
        pack_cnt_q <= word_done ? '0 : pack_cnt_q + 1'b1;
        rep_cnt_q  <= rep_cnt_d;
      end
    end
  end

  // four-phase seed handshake toward the generator
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      buf_full_q <= 1'b0;
      seed_ack_q <= 1'b0;
    end else begin
      if (word_done) begin
        buf_full_q <= 1'b1;
      end
      if (!seed_ack_q && seed_req_i && buf_full_q) begin
        seed_ack_q <= 1'b1;
      end else if (seed_ack_q && !seed_req_i) begin
        // word consumed, empty the buffer
        seed_ack_q <= 1'b0;
        buf_full_q <= 1'b0;
      end
    end
  end

  assign seed_ack_o  = seed_ack_q;
  assign seed_data_o = seed_buf_q;

  // sticky until reset
  assign intr_es_health_test_failed_o = intr_q;

endmodule

`default_nettype wire

/* hdl/csrng.sv */
`timescale 1ns/1ps
`default_nettype none

module csrng (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  output logic                       seed_req_o,
  input  logic                       seed_ack_i,
  input  rot_entropy_pkg::seed_word_t seed_data_i,
  input  logic                       gen_req_i,
  output logic                       gen_ack_o,
  output rot_entropy_pkg::seed_word_t gen_data_o
);

  import rot_entropy_pkg::*;

  cs_state_e   cs_state_q;
  seed_word_t  state_q;
  reseed_cnt_t gen_cnt_q;
  logic        seed_req_q;
  logic        reseed_due;

  // one galois step, shift right and fold in the taps
  function automatic seed_word_t lfsr_step(seed_word_t cur);
    seed_word_t nxt;
    nxt = cur >> 1;
    if (cur[0]) begin
      nxt = nxt ^ CsrngLfsrTaps;
    end
    return nxt;
  endfunction

  // counter starts at the limit so the first generate reseeds
  assign reseed_due = (gen_cnt_q == reseed_cnt_t'(GenPerReseed));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cs_state_q <= CsIdle;
      state_q    <= CsrngInitState;
      gen_cnt_q  <= reseed_cnt_t'(GenPerReseed);
      seed_req_q <= 1'b0;
    end else begin
      case (cs_state_q)
        CsIdle: begin
          if (gen_req_i) begin
            if (reseed_due) begin
              seed_req_q <= 1'b1;
              cs_state_q <= CsReseed;
            end else begin
              cs_state_q <= CsGen;
            end
          end
        end
        CsReseed: begin
          if (seed_req_q && seed_ack_i) begin
            // mix the fresh seed in, then release the request
            state_q    <= state_q ^ seed_data_i;
            gen_cnt_q  <= '0;
            seed_req_q <= 1'b0;
          end else if (!seed_req_q && !seed_ack_i) begin
            // seed link back to idle
            cs_state_q <= CsGen;
          end
        end
        CsGen: begin
          state_q    <= lfsr_step(state_q);
          gen_cnt_q  <= gen_cnt_q + 1'b1;
          cs_state_q <= CsAck;
        end
        CsAck: begin
          // hold the word until the requester lets go
          if (!gen_req_i) begin
            cs_state_q <= CsIdle;
          end
        end
        default: begin
          cs_state_q <= CsIdle;
        end
      endcase
    end
  end

  assign seed_req_o = seed_req_q;

  // state only moves in CsReseed and CsGen so data holds during ack
  assign gen_ack_o  = (cs_state_q == CsAck);
  assign gen_data_o = state_q;

endmodule

`default_nettype wire

/* hdl/edn.sv */
`timescale 1ns/1ps
`default_nettype none

module edn (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  rot_entropy_pkg::ep_mask_t   ep_req_i,
  output rot_entropy_pkg::ep_mask_t   ep_ack_o,
  output rot_entropy_pkg::seed_word_t ep_data_o,
  output logic                       gen_req_o,
  input  logic                       gen_ack_i,
  input  rot_entropy_pkg::seed_word_t gen_data_i
);

  import rot_entropy_pkg::*;

  edn_state_e edn_state_q;

  // granted endpoint and the previous grant
  ep_idx_t    sel_q;
  ep_idx_t    last_q;

  // round-robin pick
  ep_idx_t    cand;
  ep_idx_t    pick_idx;
  logic       pick_found;

  seed_word_t data_q;
  logic       gen_req_q;

  // search starts one past the last grant and wraps
  always_comb begin
    pick_found = 1'b0;
    pick_idx   = '0;
    cand       = '0;
    for (int i = 0; i < NumEndPoints; i++) begin
      cand = ep_idx_t'(last_q + 1 + i);
      if (!pick_found && ep_req_i[cand]) begin
        pick_found = 1'b1;
        pick_idx   = cand;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      edn_state_q <= EdnIdle;
      sel_q       <= '0;
      // first search then begins at endpoint 0
      last_q      <= ep_idx_t'(NumEndPoints - 1);
      gen_req_q   <= 1'b0;
    end else begin
      case (edn_state_q)
        EdnIdle: begin
          if (pick_found) begin
            sel_q       <= pick_idx;
            gen_req_q   <= 1'b1;
            edn_state_q <= EdnFetch;
          end
        end
        EdnFetch: begin
          // word captured below, drop the request
          if (gen_ack_i) begin
            gen_req_q   <= 1'b0;
            edn_state_q <= EdnAck;
          end
        end
        EdnAck: begin
          edn_state_q <= EdnRelease;
        end
        EdnRelease: begin
          // ack falls once the endpoint has let go
          if (!ep_req_i[sel_q]) begin
            last_q      <= sel_q;
            edn_state_q <= EdnIdle;
          end
        end
        default: begin
          edn_state_q <= EdnIdle;
        end
      endcase
    end
  end

  // fetched word
  always_ff @(posedge clk_i) begin
    if ((edn_state_q == EdnFetch) && gen_ack_i) begin
      data_q <= gen_data_i;
    end
  end

  // only the granted endpoint sees an ack
  always_comb begin
    ep_ack_o = '0;
    if (edn_state_q == EdnRelease) begin
      ep_ack_o[sel_q] = 1'b1;
    end
  end

  assign ep_data_o = data_q;
  assign gen_req_o = gen_req_q;

endmodule

`default_nettype wire

/* hdl/rot_entropy_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rot_entropy_top (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  rot_entropy_pkg::rng_sample_t es_rng_sample_i,
  input  logic                        es_rng_valid_i,
  output logic                        es_rng_enable_o,
  input  rot_entropy_pkg::ep_mask_t    ep_req_i,
  output rot_entropy_pkg::ep_mask_t    ep_ack_o,
  output rot_entropy_pkg::seed_word_t  ep_data_o,
  output logic                        intr_es_health_test_failed_o
);

  import rot_entropy_pkg::*;

  // seed link, generator to entropy source
  logic       seed_req;
  logic       seed_ack;
  seed_word_t seed_data;

  // generate link, distribution to generator
  logic       gen_req;
  logic       gen_ack;
  seed_word_t gen_data;

  // noise sampling and health test
  entropy_src u_entropy_src (
    .clk_i                        (clk_i),
    .rst_n_i                      (rst_n_i),
    .es_rng_sample_i              (es_rng_sample_i),
    .es_rng_valid_i               (es_rng_valid_i),
    .es_rng_enable_o              (es_rng_enable_o),
    .seed_req_i                   (seed_req),
    .seed_ack_o                   (seed_ack),
    .seed_data_o                  (seed_data),
    .intr_es_health_test_failed_o (intr_es_health_test_failed_o)
  );

  // deterministic generator
  csrng u_csrng (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .seed_req_o  (seed_req),
    .seed_ack_i  (seed_ack),
    .seed_data_i (seed_data),
    .gen_req_i   (gen_req),
    .gen_ack_o   (gen_ack),
    .gen_data_o  (gen_data)
  );

  // endpoint arbitration and delivery
  edn u_edn (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ep_req_i   (ep_req_i),
    .ep_ack_o   (ep_ack_o),
    .ep_data_o  (ep_data_o),
    .gen_req_o  (gen_req),
    .gen_ack_i  (gen_ack),
    .gen_data_i (gen_data)
  );

endmodule

`default_nettype wire

/* verification/rot_entropy_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module rot_entropy_chk (
  input logic                        clk_i,
  input logic                        rst_n_i,
  input rot_entropy_pkg::ep_mask_t   ep_req_i,
  input rot_entropy_pkg::ep_mask_t   ep_ack_i,
  input rot_entropy_pkg::seed_word_t ep_data_i
);

  import rot_entropy_pkg::*;

  // shared bus, one owner at a time
  assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(ep_ack_i))
    else $error("more than one endpoint ack is high");

  // word must not move under a held ack
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ep_ack_i != '0) && ($past(ep_ack_i) != '0) |-> $stable(ep_data_i))
    else $error("ep_data_o changed while an ack was high");

  // four-phase order, req drops before ack
  for (genvar n = 0; n < NumEndPoints; n++) begin : g_ack_release
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $fell(ep_ack_i[n]) |-> !$past(ep_req_i[n]))
      else $error("endpoint %0d ack fell while its req was high", n);
  end

endmodule

bind edn rot_entropy_chk i_chk (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .ep_req_i  (ep_req_i),
  .ep_ack_i  (ep_ack_o),
  .ep_data_i (ep_data_o)
);

`default_nettype wire

/* verification/tb_rot_entropy.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rot_entropy;

  import rot_entropy_pkg::*;

  localparam int WatchdogCycles = 20000;
  localparam int AckTimeout     = 2000;

  logic        clk;
  logic        rst_n;
  rng_sample_t rng_sample;
  logic        rng_valid;
  logic        rng_enable;
  ep_mask_t    ep_req;
  ep_mask_t    ep_ack;
  seed_word_t  ep_data;
  logic        intr;

  // stimulus state
  integer      seed;
  logic [31:0] rnd;
  logic        stuck;
  int          errors;
  int          checks;
  int          issued;

  // reference model of the chain
  seed_word_t  seeds[$];
  seed_word_t  pack;
  int          pack_n;
  rng_sample_t last_sample;
  int          run;
  seed_word_t  gen_state;
  int          gen_since;
  seed_word_t  expected_word;
  ep_mask_t    prev_ack;
  int          ack_order[$];

  rot_entropy_top i_dut (
    .clk_i                        (clk),
    .rst_n_i                      (rst_n),
    .es_rng_sample_i              (rng_sample),
    .es_rng_valid_i               (rng_valid),
    .es_rng_enable_o              (rng_enable),
    .ep_req_i                     (ep_req),
    .ep_ack_o                     (ep_ack),
    .ep_data_o                    (ep_data),
    .intr_es_health_test_failed_o (intr)
  );

  always #4 clk = ~clk;

  // shift right and fold the mask in when a one drops out
  function automatic seed_word_t galois_next(seed_word_t s);
    return {1'b0, s[31:1]} ^ (s[0] ? CsrngLfsrTaps : 32'h0);
  endfunction

  // packing and repetition run as the noise source sees them
  function automatic void take_sample(rng_sample_t s);
    if (run != 0 && s == last_sample) begin
      run++;
    end else begin
      run = 1;
    end
    last_sample = s;
    if (run == RepCntThresh) begin
      // partial word lost and the run restarts
      pack_n = 0;
      run    = 0;
    end else begin
      pack = {s, pack[31:4]};
      pack_n++;
      if (pack_n == SamplesPerWord) begin
        seeds.push_back(pack);
        pack_n = 0;
      end
    end
  endfunction

  // next delivered word with a reseed first when due
  function automatic seed_word_t predict_word();
    if (gen_since == GenPerReseed) begin
      if (seeds.size() == 0) begin
        errors++;
        $display("model has no seed word left for a reseed");
      end else begin
        gen_state = gen_state ^ seeds.pop_front();
      end
      gen_since = 0;
    end
    gen_state = galois_next(gen_state);
    gen_since++;
    return gen_state;
  endfunction

  function automatic int ack_index(ep_mask_t a);
    int idx;
    idx = -1;
    for (int i = 0; i < NumEndPoints; i++) begin
      if (a[i]) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  // waits on the falling edge where ack is settled
  task automatic wait_ack(input int idx, input logic level);
    int n;
    n = 0;
    while (ep_ack[idx] !== level && n < AckTimeout) begin
      @(negedge clk);
      n++;
    end
    if (ep_ack[idx] !== level) begin
      errors++;
      $display("endpoint %0d ack did not go to %0b in time", idx, level);
    end
  endtask

  // one four-phase transfer where hold keeps req up after the ack
  task automatic request(input int idx, input int hold);
    @(posedge clk);
    #1;
    ep_req[idx] = 1'b1;
    issued++;
    wait_ack(idx, 1'b1);
    repeat (hold) @(posedge clk);
    @(posedge clk);
    #1;
    ep_req[idx] = 1'b0;
    wait_ack(idx, 1'b0);
  endtask

  // noise feeder with a new distinct sample every cycle
  always @(posedge clk) begin
    if (rst_n) begin
      #1;
      rng_valid = 1'b1;
      if (stuck) begin
        rng_sample = 4'ha;
      end else begin
        rnd = $random(seed);
        rng_sample = rng_sample ^ ((rnd[3:0] == 4'h0) ? 4'h1 : rnd[3:0]);
      end
    end
  end

  // model update and data check on the falling edge where inputs are settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (rng_valid && rng_enable) begin
        take_sample(rng_sample);
      end
      if (ep_ack != '0 && prev_ack == '0) begin
        checks++;
        ack_order.push_back(ack_index(ep_ack));
        expected_word = predict_word();
        assert (ep_data == expected_word) else begin
          errors++;
          $display("Fail ep_data_o expected %08h actual %08h", expected_word, ep_data);
        end
      end
      prev_ack = ep_ack;
    end
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    errors++;
    $display("watchdog expired after %0d cycles, run did not finish", WatchdogCycles);
    $display("errors: %0d  checks: %0d", errors, checks);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    int n;
    clk           = 1'b0;
    rst_n         = 1'b0;
    rng_sample    = 4'h0;
    rng_valid     = 1'b0;
    ep_req        = '0;
    stuck         = 1'b0;
    seed          = 32'h842c_215e;
    errors        = 0;
    checks        = 0;
    issued        = 0;
    pack          = '0;
    pack_n        = 0;
    last_sample   = '0;
    run           = 0;
    gen_state     = CsrngInitState;
    gen_since     = GenPerReseed;
    expected_word = '0;
    prev_ack      = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // first word is init state xor first seed stepped once
    request(0, 0);

    // while idle the buffer refills and the source stalls
    n = 0;
    while (rng_enable && n < 200) begin
      @(negedge clk);
      n++;
    end
    assert (!rng_enable) else begin
      errors++;
      $display("Fail es_rng_enable_o expected 0 actual %h", rng_enable);
    end
    repeat (40) @(posedge clk);
    // last grant on 3 so the next search starts at 0
    request(3, 0);

    // all four at once are served round-robin from endpoint 0
    ack_order.delete();
    fork
      request(0, 0);
      request(1, 0);
      request(2, 0);
      request(3, 0);
    join
    for (int i = 0; i < NumEndPoints; i++) begin
      assert (ack_order.size() > i && ack_order[i] == i) else begin
        errors++;
        $display("Fail ep_ack_o grant %0d expected %h actual %h", i, i,
                 (ack_order.size() > i) ? ack_order[i] : -1);
      end
    end

    // back to back requests cross several reseeds
    repeat (12) request(2, 0);

    // slow endpoint holds the others off
    ack_order.delete();
    fork
      request(1, 60);
      begin
        repeat (3) @(posedge clk);
        request(2, 0);
      end
      begin
        repeat (3) @(posedge clk);
        request(3, 0);
      end
    join
    // endpoint 1 first and then 2 and 3 in round-robin order after it lets go
    for (int i = 0; i < 3; i++) begin
      assert (ack_order.size() > i && ack_order[i] == i + 1) else begin
        errors++;
        $display("Fail ep_ack_o grant %0d expected %h actual %h", i, i + 1,
                 (ack_order.size() > i) ? ack_order[i] : -1);
      end
    end

    // no repeated samples so far
    assert (!intr) else begin
      errors++;
      $display("Fail intr_es_health_test_failed_o expected 0 actual %h", intr);
    end

    // stuck noise source until the health test trips
    stuck = 1'b1;
    n = 0;
    while (!intr && n < 40) begin
      request(0, 0);
      n++;
    end
    stuck = 1'b0;
    repeat (6) request(1, 0);
    assert (intr) else begin
      errors++;
      $display("Fail intr_es_health_test_failed_o expected 1 actual %h", intr);
    end

    assert (checks == issued) else begin
      errors++;
      $display("Fail delivered words expected %h actual %h", issued, checks);
    end
    $display("errors: %0d  checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
hdl/rot_entropy_pkg.sv
hdl/entropy_src.sv
hdl/csrng.sv
hdl/edn.sv
hdl/rot_entropy_top.sv
verification/rot_entropy_chk.sv
verification/tb_rot_entropy.sv

/* Makefile */
TOP = tb_rot_entropy

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, write sim.log and check it"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then \
		echo "simulation failed, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
